//--- compile.f
+incdir+.
sdram_fifo_pkg.sv
stream_fifo.sv
word_packer_fifo.sv
bulk_buffer_ram.sv
burst_mover.sv
fill_monitor.sv
sdram_fifo_top.sv
tb_checker.sv
tb_sdram_fifo.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_sdram_fifo -f compile.f -o sim_sdram_fifo
	./obj_dir/sim_sdram_fifo | tee sim.log
	grep -qx ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_sdram_fifo.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module tb_sdram_fifo;

	localparam int SETTLE_CYCLES = 3 * (`SF_BURST + 1);
	localparam int WRITES = 64 + 3 * 32 + 37;
	localparam int READS = 10 + 3 * 16 + 22 + 18;
	// Eight settle waits, each possibly behind a string of bursts
	localparam int WATCHDOG_CYCLES = 4 * (WRITES + READS) + 8 * (SETTLE_CYCLES + 200) + 500;

	logic                    ti_clk;
	logic                    arst_n;
	logic                    data_wr;
	logic [`SF_SAMPLE_W-1:0] data_in;
	logic                    host_rd;
	logic [`SF_WORD_W-1:0]   data_out;
	logic                    data_out_rdy;
	logic [`SF_COUNT_W-1:0]  usb3_blocksize;
	logic [`SF_COUNT_W-1:0]  num_words_in_fifo;
	logic [`SF_COUNT_W-1:0]  in_fifo_numwords;
	logic [`SF_COUNT_W-1:0]  out_fifo_numwords;
	logic [`SF_COUNT_W-1:0]  ddr_numwords;
	int                      test_id;
	logic                    check_now;
	logic                    test_done;
	logic                    all_done;
	int                      errors;
	logic [31:0]             lfsr;
	int                      sizes [5] = '{0, 15, 16, 17, 64};

	sdram_fifo_top u_dut (.*);

	tb_checker u_checker (.*);

	initial begin
		ti_clk = 1'b0;
		forever #50 ti_clk = ~ti_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge ti_clk);
		$display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	// Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [127:0] count_snapshot();
		return {num_words_in_fifo, in_fifo_numwords, out_fifo_numwords, ddr_numwords};
	endfunction

	////////////////////
	// Stimulus tasks
	////////////////////

	task automatic write_samples(input int n);
		logic [`SF_SAMPLE_W-1:0] s;
		int                      b;
		repeat (n) begin
			@(negedge ti_clk);
			for (b = 0; b < `SF_SAMPLE_W; b++) begin
				lfsr = lfsr_step(lfsr);
				s[b] = lfsr[0];
			end
			data_in = s;
			data_wr = 1'b1;
		end
		@(negedge ti_clk);
		data_wr = 1'b0;
	endtask

	task automatic read_words(input int n);
		repeat (n) begin
			@(negedge ti_clk);
			host_rd = 1'b1;
		end
		@(negedge ti_clk);
		host_rd = 1'b0;
	endtask

	task automatic wait_output();
		while (out_fifo_numwords == '0) begin
			@(negedge ti_clk);
		end
	endtask

	// No burst can run while the counts stay still this long
	task automatic wait_settled();
		logic [127:0] snap;
		int           still;
		still = 0;
		snap  = count_snapshot();
		while (still < SETTLE_CYCLES) begin
			@(negedge ti_clk);
			if (count_snapshot() != snap) begin
				snap  = count_snapshot();
				still = 0;
			end else begin
				still++;
			end
		end
	endtask

	task automatic request_check();
		@(negedge ti_clk);
		check_now = 1'b1;
		@(negedge ti_clk);
		check_now = 1'b0;
	endtask

	task automatic finish_test();
		@(negedge ti_clk);
		test_done = 1'b1;
		@(negedge ti_clk);
		test_done = 1'b0;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		arst_n         = 1'b0;
		data_wr        = 1'b0;
		data_in        = '0;
		host_rd        = 1'b0;
		usb3_blocksize = 32'd4;
		test_id        = 1;
		check_now      = 1'b0;
		test_done      = 1'b0;
		all_done       = 1'b0;
		lfsr           = 32'h6920_ff6a;
		repeat (5) @(negedge ti_clk);
		arst_n = 1'b1;

		// State straight out of reset
		repeat (3) @(negedge ti_clk);
		request_check();
		finish_test();

		// Whole bursts in, then a partial read
		test_id = 2;
		write_samples(64);
		wait_output();
		wait_settled();
		request_check();
		read_words(10);
		wait_settled();
		request_check();
		finish_test();

		// Several rounds through the bulk store, then drain the output buffer
		test_id = 3;
		repeat (3) begin
			write_samples(32);
			wait_settled();
			read_words(16);
		end
		read_words(22);
		wait_settled();
		request_check();
		finish_test();

		// Odd count leaves a remainder in the input buffer
		test_id = 4;
		write_samples(37);
		wait_output();
		wait_settled();
		request_check();
		finish_test();

		test_id = 5;
		foreach (sizes[i]) begin
			@(negedge ti_clk);
			usb3_blocksize = sizes[i];
			request_check();
		end
		finish_test();

		// Two reads past the end must hold the last word
		test_id = 6;
		read_words(18);
		wait_settled();
		request_check();
		finish_test();

		@(negedge ti_clk);
		all_done = 1'b1;
		@(negedge ti_clk);
		all_done = 1'b0;
		repeat (2) @(negedge ti_clk);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module tb_checker (
	input  logic                    ti_clk,
	input  logic                    arst_n,
	input  logic                    data_wr,
	input  logic [`SF_SAMPLE_W-1:0] data_in,
	input  logic                    host_rd,
	input  logic [`SF_WORD_W-1:0]   data_out,
	input  logic                    data_out_rdy,
	input  logic [`SF_COUNT_W-1:0]  usb3_blocksize,
	input  logic [`SF_COUNT_W-1:0]  num_words_in_fifo,
	input  logic [`SF_COUNT_W-1:0]  in_fifo_numwords,
	input  logic [`SF_COUNT_W-1:0]  out_fifo_numwords,
	input  logic [`SF_COUNT_W-1:0]  ddr_numwords,
	input  int                      test_id,
	input  logic                    check_now,
	input  logic                    test_done,
	input  logic                    all_done,
	output int                      errors
);

	// Only whole bursts of pairs leave the input buffer
	localparam int PAIR_SAMPLES = 2 * `SF_BURST;

	logic [`SF_SAMPLE_W-1:0] samples_q [$];
	logic [`SF_WORD_W-1:0]   last_word = '0;
	logic [`SF_SAMPLE_W-1:0] sample_seen = '0;
	logic [`SF_COUNT_W-1:0]  bs_seen = '0;
	logic                    wr_seen = 1'b0;
	logic                    rd_seen = 1'b0;
	logic                    chk_seen = 1'b0;
	logic                    done_seen = 1'b0;
	logic                    end_seen = 1'b0;
	int                      id_seen = 0;
	int                      written = 0;
	int                      words_read = 0;
	int                      test_errors = 0;
	int                      tests_run = 0;
	int                      checks = 0;
	int                      error_count = 0;

	assign errors = error_count;

	// Oldest sample of a pair sits in the low half
	function automatic logic [`SF_WORD_W-1:0] expected_word();
		logic [`SF_SAMPLE_W-1:0] lo;
		logic [`SF_SAMPLE_W-1:0] hi;
		lo = samples_q.pop_front();
		hi = samples_q.pop_front();
		return {hi, lo};
	endfunction

	// Words of all whole bursts written so far, less those the host has taken
	function automatic int expected_out_words();
		return (written / PAIR_SAMPLES) * `SF_BURST - words_read;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
			error_count++;
			test_errors++;
		end
	endtask

	////////////////////
	// Input capture
	////////////////////

	always @(posedge ti_clk) begin
		wr_seen     <= data_wr && arst_n;
		sample_seen <= data_in;
		rd_seen     <= host_rd && arst_n;
		chk_seen    <= check_now;
		done_seen   <= test_done;
		end_seen    <= all_done;
		id_seen     <= test_id;
		bs_seen     <= usb3_blocksize;
	end

	////////////////////
	// Comparison
	////////////////////

	always @(negedge ti_clk) begin
		if (wr_seen) begin
			samples_q.push_back(sample_seen);
			written++;
		end
		if (rd_seen) begin
			// Reads come after settling, so every whole burst is already waiting
			if (expected_out_words() > 0) begin
				last_word = expected_word();
				words_read++;
			end
			compare("data_out", data_out, last_word);
		end
		if (chk_seen) begin
			compare("num_words_in_fifo", num_words_in_fifo, 32'(written - 2 * words_read));
			compare("in_fifo_numwords", in_fifo_numwords, 32'(written % PAIR_SAMPLES));
			compare("out_fifo_numwords", out_fifo_numwords, 32'(2 * expected_out_words()));
			// Bursts drain the bulk store while the output buffer has room
			compare("ddr_numwords", ddr_numwords, 32'(0));
			compare("data_out_rdy", 32'(data_out_rdy), 32'(expected_out_words() >= bs_seen));
			compare("data_out", data_out, last_word);
		end
		if (done_seen) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0d: ok", id_seen);
			end else begin
				$display("test %0d: %0d errors", id_seen, test_errors);
			end
			test_errors = 0;
		end
		if (end_seen) begin
			$display("%0d tests, %0d checks, %0d errors", tests_run, checks, error_count);
		end
	end

endmodule

//--- sdram_fifo_top.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module sdram_fifo_top (
	input  logic                     ti_clk,
	input  logic                     arst_n,
	input  logic                     data_wr,
	input  logic [`SF_SAMPLE_W-1:0]  data_in,
	input  logic                     host_rd,
	output logic [`SF_WORD_W-1:0]    data_out,
	output logic                     data_out_rdy,
	input  logic [`SF_COUNT_W-1:0]   usb3_blocksize,
	output logic [`SF_COUNT_W-1:0]   num_words_in_fifo,
	output logic [`SF_COUNT_W-1:0]   in_fifo_numwords,
	output logic [`SF_COUNT_W-1:0]   out_fifo_numwords,
	output logic [`SF_COUNT_W-1:0]   ddr_numwords
);

	logic                          in_rd;
	logic [`SF_WORD_W-1:0]         in_data;
	logic [`SF_IN_ENT_W-1:0]       in_entries;
	sdram_fifo_pkg::mem_req_t      mem_req;
	logic [`SF_WORD_W-1:0]         mem_rdata;
	logic                          out_wr;
	logic [`SF_WORD_W-1:0]         out_data;
	logic [`SF_OUT_CNT_W-1:0]      out_free;
	// Each field is driven by a different stage
	wire sdram_fifo_pkg::stage_counts_t counts;

	word_packer_fifo u_packer (
		.ti_clk  (ti_clk),
		.arst_n  (arst_n),
		.wr      (data_wr),
		.sample  (data_in),
		.rd      (in_rd),
		.entry   (in_data),
		.entries (in_entries),
		.samples (counts.in_samples)
	);

	burst_mover u_mover (
		.ti_clk     (ti_clk),
		.arst_n     (arst_n),
		.in_rd      (in_rd),
		.in_data    (in_data),
		.in_entries (in_entries),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.out_wr     (out_wr),
		.out_data   (out_data),
		.out_free   (out_free),
		.bulk_words (counts.bulk_words)
	);

	bulk_buffer_ram u_bulk (
		.ti_clk  (ti_clk),
		.mem_req (mem_req),
		.rdata   (mem_rdata)
	);

	stream_fifo #(
		.DEPTH (`SF_OUT_DEPTH)
	) u_out_fifo (
		.ti_clk (ti_clk),
		.arst_n (arst_n),
		.wr     (out_wr),
		.wdata  (out_data),
		.rd     (host_rd),
		.rdata  (data_out),
		.words  (counts.out_words),
		.free   (out_free)
	);

	fill_monitor u_monitor (
		.ti_clk         (ti_clk),
		.arst_n         (arst_n),
		.counts         (counts),
		.usb3_blocksize (usb3_blocksize),
		.total          (num_words_in_fifo),
		.in_numwords    (in_fifo_numwords),
		.out_numwords   (out_fifo_numwords),
		.ddr_numwords   (ddr_numwords),
		.out_rdy        (data_out_rdy)
	);

endmodule

//--- fill_monitor.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module fill_monitor (
	input  logic                          ti_clk,
	input  logic                          arst_n,
	input  sdram_fifo_pkg::stage_counts_t counts,
	input  logic [`SF_COUNT_W-1:0]        usb3_blocksize,
	output logic [`SF_COUNT_W-1:0]        total,
	output logic [`SF_COUNT_W-1:0]        in_numwords,
	output logic [`SF_COUNT_W-1:0]        out_numwords,
	output logic [`SF_COUNT_W-1:0]        ddr_numwords,
	output logic                          out_rdy
);

	localparam int CW = `SF_COUNT_W;

	sdram_fifo_pkg::bulk_addr_u ddr_span;
	logic [CW-1:0]              in_half;
	logic [CW-1:0]              out_half;
	logic [CW-1:0]              ddr_half;

	// Everything is reported in 16-bit sample units
	always_comb begin
		in_half  = CW'(counts.in_samples);
		out_half = CW'({counts.out_words, 1'b0});
		// Byte span of the bulk words, halved to get samples
		ddr_span = '0;
		ddr_span.split.word_idx = counts.bulk_words;
		ddr_half = CW'(ddr_span.byte_addr >> 1);
	end

	always_ff @(posedge ti_clk or negedge arst_n) begin
		if (!arst_n) begin
			total        <= '0;
			in_numwords  <= '0;
			out_numwords <= '0;
			ddr_numwords <= '0;
			out_rdy      <= 1'b0;
		end else begin
			in_numwords  <= in_half;
			out_numwords <= out_half;
			ddr_numwords <= ddr_half;
			total        <= in_half + out_half + ddr_half;
			// Host may take a block once the output buffer holds one
			out_rdy      <= (CW'(counts.out_words) >= usb3_blocksize);
		end
	end

endmodule

//--- burst_mover.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module burst_mover (
	input  logic                     ti_clk,
	input  logic                     arst_n,
	output logic                     in_rd,
	input  logic [`SF_WORD_W-1:0]    in_data,
	input  logic [`SF_IN_ENT_W-1:0]  in_entries,
	output sdram_fifo_pkg::mem_req_t mem_req,
	input  logic [`SF_WORD_W-1:0]    mem_rdata,
	output logic                     out_wr,
	output logic [`SF_WORD_W-1:0]    out_data,
	input  logic [`SF_OUT_CNT_W-1:0] out_free,
	output logic [`SF_BULK_AW-1:0]   bulk_words
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WRITE = 2'd1;
	localparam logic [1:0] ST_READ  = 2'd2;

	localparam int BW = $clog2(`SF_BURST + 1);
	localparam logic [BW-1:0] LAST_BEAT = BW'(`SF_BURST);
	localparam logic [`SF_ADDR_W-1:0] WORD_BYTES = `SF_ADDR_W'(4);

	logic [1:0]                 state;
	logic [BW-1:0]              beat;
	sdram_fifo_pkg::bulk_addr_u wr_addr;
	sdram_fifo_pkg::bulk_addr_u rd_addr;
	logic                       start_rd;
	logic                       start_wr;
	logic                       issue;
	logic                       land;

	// Word index difference, wraps freely when the store laps
	assign bulk_words = wr_addr.split.word_idx - rd_addr.split.word_idx;

	assign start_rd = (bulk_words >= `SF_BURST) && (out_free >= `SF_BURST);
	assign start_wr = (in_entries >= `SF_BURST);

	// Source side works on beats 0..B-1, sink side one beat later
	assign issue = (beat != LAST_BEAT);
	assign land  = (beat != '0);

	////////////////////
	// Datapath strobes
	////////////////////

	assign in_rd    = (state == ST_WRITE) && issue;
	assign out_wr   = (state == ST_READ) && land;
	assign out_data = mem_rdata;

	always_comb begin
		mem_req.we    = (state == ST_WRITE) && land;
		mem_req.addr  = (state == ST_READ) ? rd_addr : wr_addr;
		mem_req.wdata = in_data;
	end

	////////////////////
	// Burst FSM
	////////////////////

	always_ff @(posedge ti_clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_IDLE;
			beat    <= '0;
			wr_addr <= '0;
			rd_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					beat <= '0;
					// Draining toward the host wins a tie
					if (start_rd) begin
						state <= ST_READ;
					end else if (start_wr) begin
						state <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					if (land) begin
						wr_addr.byte_addr <= wr_addr.byte_addr + WORD_BYTES;
					end
					if (issue) begin
						beat <= beat + 1'b1;
					end else begin
						beat  <= '0;
						state <= ST_IDLE;
					end
				end
				ST_READ: begin
					if (issue) begin
						rd_addr.byte_addr <= rd_addr.byte_addr + WORD_BYTES;
						beat              <= beat + 1'b1;
					end else begin
						beat  <= '0;
						state <= ST_IDLE;
					end
				end
				default: begin
					beat  <= '0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- bulk_buffer_ram.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module bulk_buffer_ram (
	input  logic                     ti_clk,
	input  sdram_fifo_pkg::mem_req_t mem_req,
	output logic [`SF_WORD_W-1:0]    rdata
);

	localparam int WORDS = 2 ** `SF_BULK_AW;

	logic [`SF_WORD_W-1:0]  store [WORDS];
	logic [`SF_BULK_AW-1:0] idx;

	// Byte offset and lap bit play no part in the lookup
	assign idx = mem_req.addr.split.word_idx;

	////////////////////
	// Store array
	////////////////////

	always_ff @(posedge ti_clk) begin
		if (mem_req.we) begin
			store[idx] <= mem_req.wdata;
		end
	end

	// Read first, data valid one cycle after the request
	always_ff @(posedge ti_clk) begin
		rdata <= store[idx];
	end

endmodule

//--- word_packer_fifo.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module word_packer_fifo (
	input  logic                     ti_clk,
	input  logic                     arst_n,
	input  logic                     wr,
	input  logic [`SF_SAMPLE_W-1:0]  sample,
	input  logic                     rd,
	output logic [`SF_WORD_W-1:0]    entry,
	output logic [`SF_IN_ENT_W-1:0]  entries,
	output logic [`SF_IN_CNT_W-1:0]  samples
);

	logic [`SF_SAMPLE_W-1:0] low_half;
	logic                    half_valid;
	logic [`SF_IN_ENT_W-1:0] space;
	logic                    accept;
	logic                    pair_wr;

	////////////////////
	// Sample pairing
	////////////////////

	// Samples are dropped while the entry store is full
	assign accept  = wr && (space != '0);
	assign pair_wr = accept && half_valid;

	// First sample of a pair waits here for its partner
	always_ff @(posedge ti_clk) begin
		if (accept && !half_valid) begin
			low_half <= sample;
		end
	end

	always_ff @(posedge ti_clk or negedge arst_n) begin
		if (!arst_n) begin
			half_valid <= 1'b0;
		end else if (accept) begin
			half_valid <= !half_valid;
		end
	end

	// Two samples per entry plus a lone pending one
	assign samples = {entries, half_valid};

	////////////////////
	// Entry store
	////////////////////

	// Second sample lands in the high half
	stream_fifo #(
		.DEPTH (`SF_IN_DEPTH)
	) u_store (
		.ti_clk (ti_clk),
		.arst_n (arst_n),
		.wr     (pair_wr),
		.wdata  ({sample, low_half}),
		.rd     (rd),
		.rdata  (entry),
		.words  (entries),
		.free   (space)
	);

endmodule

//--- stream_fifo.sv
`timescale 1ns/10ps
`include "sdram_fifo_defs.svh"

module stream_fifo #(
	parameter int DEPTH = `SF_OUT_DEPTH
) (
	input  logic                   ti_clk,
	input  logic                   arst_n,
	input  logic                   wr,
	input  logic [`SF_WORD_W-1:0]  wdata,
	input  logic                   rd,
	output logic [`SF_WORD_W-1:0]  rdata,
	output logic [$clog2(DEPTH):0] words,
	output logic [$clog2(DEPTH):0] free
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

	logic [`SF_WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0]         wr_ptr;
	logic [AW-1:0]         rd_ptr;
	logic                  push;
	logic                  pop;

	// Writes into a full buffer are lost
	assign push = wr && (words != FULL_COUNT);
	// An empty read leaves rdata holding the last word
	assign pop  = rd && (words != '0);
	assign free = FULL_COUNT - words;

	always_ff @(posedge ti_clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge ti_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			words  <= '0;
			rdata  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Popped word shows on the cycle after the strobe
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				rdata  <= mem[rd_ptr];
			end
			words <= words + (AW + 1)'(push) - (AW + 1)'(pop);
		end
	end

endmodule

//--- sdram_fifo_pkg.sv
`include "sdram_fifo_defs.svh"

package sdram_fifo_pkg;

	// One bulk store address, seen either as a flat byte address
	// or split into its word index and byte offset
	typedef union packed {
		logic [`SF_ADDR_W-1:0] byte_addr;
		struct packed {
			// Toggles once per lap of the store
			logic                   spare;
			logic [`SF_BULK_AW-1:0] word_idx;
			logic [1:0]             byte_lsb;
		} split;
	} bulk_addr_u;

	// Stage occupancy as each block counts it
	typedef struct packed {
		logic [`SF_IN_CNT_W-1:0]  in_samples;
		logic [`SF_OUT_CNT_W-1:0] out_words;
		logic [`SF_BULK_AW-1:0]   bulk_words;
	} stage_counts_t;

	// Single-port request into the bulk store
	typedef struct packed {
		logic                  we;
		bulk_addr_u            addr;
		logic [`SF_WORD_W-1:0] wdata;
	} mem_req_t;

endpackage

//--- sdram_fifo_defs.svh
`ifndef SDRAM_FIFO_DEFS_SVH
`define SDRAM_FIFO_DEFS_SVH

// Sample and stored word widths
`define SF_SAMPLE_W 16
`define SF_WORD_W 32

// On-chip buffer depths in 32-bit entries
`define SF_IN_DEPTH 64
`define SF_OUT_DEPTH 64

// Bulk store size is 2**SF_BULK_AW words
`define SF_BULK_AW 10

// Words moved per burst
`define SF_BURST 8

// Occupancy outputs
`define SF_COUNT_W 32

// Derived widths
`define SF_IN_ENT_W ($clog2(`SF_IN_DEPTH) + 1)
`define SF_IN_CNT_W (`SF_IN_ENT_W + 1)
`define SF_OUT_CNT_W ($clog2(`SF_OUT_DEPTH) + 1)
`define SF_ADDR_W (`SF_BULK_AW + 3)

`endif
